// ==== design/exe_config.svh ====
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

// Datapath word width
`define EXE_DATA_W 32

// Physical register tag width, as used by issue queue and register file
`define EXE_TAG_W 6

// Architectural register number width
`define EXE_REG_W 5

`endif

// ==== design/isaPkg.sv ====
`default_nettype none

package isaPkg;

    // ************************************************************************
    // ALU operation codes carried with each issued item
    // ************************************************************************
    typedef enum logic [5:0] {
        ALU_ADD   = 6'd0,  ALU_SUB   = 6'd1,  ALU_AND   = 6'd2,  ALU_OR    = 6'd3,
        ALU_XOR   = 6'd4,  ALU_NOR   = 6'd5,  ALU_SLT   = 6'd6,  ALU_SLTU  = 6'd7,
        ALU_SLL   = 6'd8,  ALU_SRL   = 6'd9,  ALU_SRA   = 6'd10, ALU_LUI   = 6'd11,
        ALU_MULT  = 6'd12, ALU_MULTU = 6'd13, ALU_MFHI  = 6'd14, ALU_MFLO  = 6'd15,
        ALU_MTHI  = 6'd16, ALU_MTLO  = 6'd17, ALU_PASSA = 6'd18, ALU_PASSB = 6'd19
    } aluOp_t;

    // ************************************************************************
    // Instruction word, seen as R format or I format
    // ************************************************************************
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rView_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iView_t;

    typedef union packed {
        rView_t r;
        iView_t i;
    } instrWord_t;

    // Branch opcodes
    localparam logic [5:0] OP_REGIMM = 6'b000001;
    localparam logic [5:0] OP_BEQ    = 6'b000100;
    localparam logic [5:0] OP_BNE    = 6'b000101;
    localparam logic [5:0] OP_BLEZ   = 6'b000110;
    localparam logic [5:0] OP_BGTZ   = 6'b000111;

    // REGIMM sub-codes in rt
    localparam logic [4:0] RT_BLTZ = 5'b00000;
    localparam logic [4:0] RT_BGEZ = 5'b00001;

endpackage

`default_nettype wire

// ==== design/exePkg.sv ====
`default_nettype none

`include "exe_config.svh"

package exePkg;

    // ************************************************************************
    // Pipeline-side register naming
    // ************************************************************************

    // Physical tag from rename, also the broadcast key
    typedef logic [`EXE_TAG_W-1:0] physTag_t;

    // Architectural destination number
    typedef logic [`EXE_REG_W-1:0] archReg_t;

endpackage

`default_nettype wire

// ==== design/branchCompare.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module branchCompare (
    input  isaPkg::instrWord_t      Instr,
    input  logic [`EXE_DATA_W-1:0]  OperandA,
    input  logic [`EXE_DATA_W-1:0]  OperandB,
    input  logic                    Jump,
    output logic                    Taken
);
    import isaPkg::*;

    // Shared compare terms
    logic operandsEqual;
    logic aNegative;
    logic aZero;
    logic condTaken;

    assign operandsEqual = (OperandA == OperandB);
    // Sign bit gives signed A below zero
    assign aNegative     = OperandA[`EXE_DATA_W-1];
    assign aZero         = (OperandA == '0);

    // Branch condition, decoded through the I view
    always_comb begin
        case (Instr.i.opcode)
            OP_BEQ:  condTaken = operandsEqual;
            OP_BNE:  condTaken = !operandsEqual;
            OP_BLEZ: condTaken = aNegative | aZero;
            OP_BGTZ: condTaken = !aNegative & !aZero;
            OP_REGIMM: begin
                // Only BLTZ and BGEZ recognised here
                if (Instr.i.rt == RT_BLTZ) begin
                    condTaken = aNegative;
                end else if (Instr.i.rt == RT_BGEZ) begin
                    condTaken = !aNegative;
                end else begin
                    condTaken = 1'b0;
                end
            end
            default: condTaken = 1'b0;
        endcase
    end

    // Jumps always taken, opcode ignored
    assign Taken = Jump | condTaken;

endmodule

`default_nettype wire

// ==== design/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module aluUnit (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    Valid,
    input  isaPkg::aluOp_t          AluControl,
    input  logic [`EXE_DATA_W-1:0]  OperandA,
    input  logic [`EXE_DATA_W-1:0]  OperandB,
    input  logic [4:0]              ShiftAmount,
    output logic [`EXE_DATA_W-1:0]  AluResult
);
    import isaPkg::*;

    localparam int W = `EXE_DATA_W;

    // HI/LO pair
    logic [W-1:0]   hi;
    logic [W-1:0]   lo;

    // Multiplier outputs
    logic [2*W-1:0] signedProduct;
    logic [2*W-1:0] unsignedProduct;
    logic [2*W-1:0] product;
    logic           lessSigned;
    logic           lessUnsigned;

    // ************************************************************************
    // Multiply, both operands widened to the full product width
    // ************************************************************************
    assign signedProduct   = $signed({{W{OperandA[W-1]}}, OperandA})
                           * $signed({{W{OperandB[W-1]}}, OperandB});
    assign unsignedProduct = {{W{1'b0}}, OperandA} * {{W{1'b0}}, OperandB};
    assign product         = (AluControl == ALU_MULTU) ? unsignedProduct : signedProduct;

    assign lessSigned   = ($signed(OperandA) < $signed(OperandB));
    assign lessUnsigned = (OperandA < OperandB);

    // ************************************************************************
    // Result select
    // ************************************************************************
    always_comb begin
        case (AluControl)
            ALU_ADD:   AluResult = OperandA + OperandB;
            ALU_SUB:   AluResult = OperandA - OperandB;
            ALU_AND:   AluResult = OperandA & OperandB;
            ALU_OR:    AluResult = OperandA | OperandB;
            ALU_XOR:   AluResult = OperandA ^ OperandB;
            ALU_NOR:   AluResult = ~(OperandA | OperandB);
            ALU_SLT:   AluResult = {{(W-1){1'b0}}, lessSigned};
            ALU_SLTU:  AluResult = {{(W-1){1'b0}}, lessUnsigned};
            // Shifts act on rt, i.e. operand B
            ALU_SLL:   AluResult = OperandB << ShiftAmount;
            ALU_SRL:   AluResult = OperandB >> ShiftAmount;
            ALU_SRA:   AluResult = $signed(OperandB) >>> ShiftAmount;
            ALU_LUI:   AluResult = {OperandB[15:0], 16'h0000};
            // Low word of product seen on the result bus
            ALU_MULT:  AluResult = product[W-1:0];
            ALU_MULTU: AluResult = product[W-1:0];
            // Reads see HI/LO from before this edge
            ALU_MFHI:  AluResult = hi;
            ALU_MFLO:  AluResult = lo;
            ALU_MTHI:  AluResult = OperandA;
            ALU_MTLO:  AluResult = OperandA;
            ALU_PASSA: AluResult = OperandA;
            ALU_PASSB: AluResult = OperandB;
            default:   AluResult = '0;
        endcase
    end

    // ************************************************************************
    // HI/LO update, same edge as the stage register
    // ************************************************************************
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            hi <= '0;
            lo <= '0;
        end else if (Valid) begin
            case (AluControl)
                ALU_MULT, ALU_MULTU: begin
                    hi <= product[2*W-1:W];
                    lo <= product[W-1:0];
                end
                ALU_MTHI: hi <= OperandA;
                ALU_MTLO: lo <= OperandA;
                default: begin
                    // No HI/LO change
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/redirectUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module redirectUnit (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    Valid,
    input  logic                    Taken,
    input  logic                    JumpReg,
    input  logic [`EXE_DATA_W-1:0]  OperandA,
    input  logic [`EXE_DATA_W-1:0]  BranchTarget,
    output logic                    RequestAltPc,
    output logic [`EXE_DATA_W-1:0]  AltAddr
);

    // First stage of the redirect pipe
    logic                   takeQ;
    logic [`EXE_DATA_W-1:0] addrQ;

    // Bubble or not-taken gives no request
    logic                   takeNow;
    logic [`EXE_DATA_W-1:0] target;

    assign takeNow = Valid & Taken;
    // Register jump uses A, else the precomputed target
    assign target  = JumpReg ? OperandA : BranchTarget;

    // Two registers give the fixed latency to fetch
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            takeQ        <= 1'b0;
            addrQ        <= '0;
            RequestAltPc <= 1'b0;
            AltAddr      <= '0;
        end else begin
            takeQ        <= takeNow;
            // Address zeroed already in stage one
            addrQ        <= takeNow ? target : '0;
            RequestAltPc <= takeQ;
            AltAddr      <= addrQ;
        end
    end

endmodule

`default_nettype wire

// ==== design/exeStageReg.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module exeStageReg (
    input  logic                    CLK,
    input  logic                    RESET,
    input  isaPkg::instrWord_t      Instr,
    input  logic [`EXE_DATA_W-1:0]  InstrPc,
    input  exePkg::archReg_t        WriteReg,
    input  logic [`EXE_DATA_W-1:0]  MemWriteData,
    input  logic                    RegWrite,
    input  isaPkg::aluOp_t          AluControl,
    input  logic                    MemRead,
    input  logic                    MemWrite,
    input  logic [`EXE_DATA_W-1:0]  AluResult,
    input  logic                    Taken,
    input  logic                    Link,
    input  logic                    IssueRegWr,
    input  exePkg::physTag_t        IssueRegWrMap,
    output isaPkg::instrWord_t      InstrOut,
    output logic [`EXE_DATA_W-1:0]  InstrPcOut,
    output logic [`EXE_DATA_W-1:0]  AluResultOut,
    output exePkg::archReg_t        WriteRegOut,
    output logic [`EXE_DATA_W-1:0]  MemWriteDataOut,
    output logic                    RegWriteOut,
    output isaPkg::aluOp_t          AluControlOut,
    output logic                    MemReadOut,
    output logic                    MemWriteOut,
    output exePkg::physTag_t        RegWrMapOut,
    output logic                    BroadcastValid,
    output exePkg::physTag_t        BroadcastMap,
    output exePkg::archReg_t        BroadcastReg,
    output logic [`EXE_DATA_W-1:0]  BroadcastValue
);
    import isaPkg::*;

    logic valid;
    logic broadcast;

    // PC of zero is a bubble
    assign valid     = (InstrPc != '0);
    // Linked jumps and non-load writes finish here
    assign broadcast = valid & ((Taken & Link) | (IssueRegWr & !MemRead));

    // ************************************************************************
    // EXE/MEM register and broadcast fields
    // ************************************************************************
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            InstrOut        <= '0;
            InstrPcOut      <= '0;
            AluResultOut    <= '0;
            WriteRegOut     <= '0;
            MemWriteDataOut <= '0;
            RegWriteOut     <= 1'b0;
            AluControlOut   <= aluOp_t'(6'd0);
            MemReadOut      <= 1'b0;
            MemWriteOut     <= 1'b0;
            RegWrMapOut     <= '0;
            BroadcastValid  <= 1'b0;
            BroadcastMap    <= '0;
            BroadcastReg    <= '0;
            BroadcastValue  <= '0;
        end else begin
            InstrOut        <= Instr;
            InstrPcOut      <= InstrPc;
            AluResultOut    <= AluResult;
            WriteRegOut     <= WriteReg;
            MemWriteDataOut <= MemWriteData;
            // Broadcast takes over the MEM-side write
            RegWriteOut     <= broadcast ? 1'b0 : RegWrite;
            AluControlOut   <= AluControl;
            MemReadOut      <= MemRead;
            MemWriteOut     <= MemWrite;
            RegWrMapOut     <= IssueRegWrMap;
            BroadcastValid  <= broadcast;
            BroadcastMap    <= IssueRegWrMap;
            BroadcastReg    <= WriteReg;
            BroadcastValue  <= AluResult;
        end
    end

endmodule

`default_nettype wire

// ==== design/executeTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module executeTop (
    input  logic                    CLK,
    input  logic                    RESET,
    // Issued item, operands already read
    input  isaPkg::instrWord_t      Instr,
    input  logic [`EXE_DATA_W-1:0]  InstrPc,
    input  logic [`EXE_DATA_W-1:0]  OperandA,
    input  logic [`EXE_DATA_W-1:0]  OperandB,
    input  exePkg::archReg_t        WriteReg,
    input  logic [`EXE_DATA_W-1:0]  MemWriteData,
    input  logic                    RegWrite,
    input  isaPkg::aluOp_t          AluControl,
    input  logic                    MemRead,
    input  logic                    MemWrite,
    input  logic [4:0]              ShiftAmount,
    // Fetch-side branch info
    input  logic [`EXE_DATA_W-1:0]  BranchTarget,
    input  logic                    JumpReg,
    input  logic                    Jump,
    input  logic                    Link,
    // Rename info from issue
    input  exePkg::physTag_t        IssueRegWrMap,
    input  logic                    IssueRegWr,
    // To MEM
    output isaPkg::instrWord_t      InstrOut,
    output logic [`EXE_DATA_W-1:0]  InstrPcOut,
    output logic [`EXE_DATA_W-1:0]  AluResultOut,
    output exePkg::archReg_t        WriteRegOut,
    output logic [`EXE_DATA_W-1:0]  MemWriteDataOut,
    output logic                    RegWriteOut,
    output isaPkg::aluOp_t          AluControlOut,
    output logic                    MemReadOut,
    output logic                    MemWriteOut,
    output exePkg::physTag_t        RegWrMapOut,
    // Result broadcast
    output logic                    BroadcastValid,
    output exePkg::physTag_t        BroadcastMap,
    output exePkg::archReg_t        BroadcastReg,
    output logic [`EXE_DATA_W-1:0]  BroadcastValue,
    // Redirect to fetch, request doubles as flush
    output logic                    RequestAltPc,
    output logic [`EXE_DATA_W-1:0]  AltAddr
);

    logic                   valid;
    logic                   taken;
    logic [`EXE_DATA_W-1:0] aluResult;

    // Bubble qualifier for ALU and redirect
    assign valid = (InstrPc != '0);

    branchCompare uBranchCompare (
        .Instr    (Instr),
        .OperandA (OperandA),
        .OperandB (OperandB),
        .Jump     (Jump),
        .Taken    (taken)
    );

    aluUnit uAluUnit (
        .CLK         (CLK),
        .RESET       (RESET),
        .Valid       (valid),
        .AluControl  (AluControl),
        .OperandA    (OperandA),
        .OperandB    (OperandB),
        .ShiftAmount (ShiftAmount),
        .AluResult   (aluResult)
    );

    redirectUnit uRedirectUnit (
        .CLK          (CLK),
        .RESET        (RESET),
        .Valid        (valid),
        .Taken        (taken),
        .JumpReg      (JumpReg),
        .OperandA     (OperandA),
        .BranchTarget (BranchTarget),
        .RequestAltPc (RequestAltPc),
        .AltAddr      (AltAddr)
    );

    // ************************************************************************
    // Stage register, forms its own bubble test from InstrPc
    // ************************************************************************
    exeStageReg uExeStageReg (
        .CLK             (CLK),
        .RESET           (RESET),
        .Instr           (Instr),
        .InstrPc         (InstrPc),
        .WriteReg        (WriteReg),
        .MemWriteData    (MemWriteData),
        .RegWrite        (RegWrite),
        .AluControl      (AluControl),
        .MemRead         (MemRead),
        .MemWrite        (MemWrite),
        .AluResult       (aluResult),
        .Taken           (taken),
        .Link            (Link),
        .IssueRegWr      (IssueRegWr),
        .IssueRegWrMap   (IssueRegWrMap),
        .InstrOut        (InstrOut),
        .InstrPcOut      (InstrPcOut),
        .AluResultOut    (AluResultOut),
        .WriteRegOut     (WriteRegOut),
        .MemWriteDataOut (MemWriteDataOut),
        .RegWriteOut     (RegWriteOut),
        .AluControlOut   (AluControlOut),
        .MemReadOut      (MemReadOut),
        .MemWriteOut     (MemWriteOut),
        .RegWrMapOut     (RegWrMapOut),
        .BroadcastValid  (BroadcastValid),
        .BroadcastMap    (BroadcastMap),
        .BroadcastReg    (BroadcastReg),
        .BroadcastValue  (BroadcastValue)
    );

endmodule

`default_nettype wire

// ==== bench/executeChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module executeCheck (
    input  wire logic                    CLK,
    input  wire logic                    RESET,
    input  wire isaPkg::instrWord_t      Instr,
    input  wire logic [`EXE_DATA_W-1:0]  InstrPc,
    input  wire logic [`EXE_DATA_W-1:0]  OperandA,
    input  wire logic [`EXE_DATA_W-1:0]  OperandB,
    input  wire exePkg::archReg_t        WriteReg,
    input  wire logic [`EXE_DATA_W-1:0]  MemWriteData,
    input  wire logic                    RegWrite,
    input  wire isaPkg::aluOp_t          AluControl,
    input  wire logic                    MemRead,
    input  wire logic                    MemWrite,
    input  wire logic [4:0]              ShiftAmount,
    input  wire logic [`EXE_DATA_W-1:0]  BranchTarget,
    input  wire logic                    JumpReg,
    input  wire logic                    Jump,
    input  wire logic                    Link,
    input  wire exePkg::physTag_t        IssueRegWrMap,
    input  wire logic                    IssueRegWr,
    input  wire isaPkg::instrWord_t      InstrOut,
    input  wire logic [`EXE_DATA_W-1:0]  InstrPcOut,
    input  wire logic [`EXE_DATA_W-1:0]  AluResultOut,
    input  wire exePkg::archReg_t        WriteRegOut,
    input  wire logic [`EXE_DATA_W-1:0]  MemWriteDataOut,
    input  wire logic                    RegWriteOut,
    input  wire isaPkg::aluOp_t          AluControlOut,
    input  wire logic                    MemReadOut,
    input  wire logic                    MemWriteOut,
    input  wire exePkg::physTag_t        RegWrMapOut,
    input  wire logic                    BroadcastValid,
    input  wire exePkg::physTag_t        BroadcastMap,
    input  wire exePkg::archReg_t        BroadcastReg,
    input  wire logic [`EXE_DATA_W-1:0]  BroadcastValue,
    input  wire logic                    RequestAltPc,
    input  wire logic [`EXE_DATA_W-1:0]  AltAddr
);
    import isaPkg::*;

    int errorCount = 0;
    int checkCount = 0;
    int redirectCount = 0;
    int broadcastCount = 0;

    // Model state, HI/LO pair
    logic [31:0] hiM = '0;
    logic [31:0] loM = '0;

    // Expected stage register contents, one cycle deep
    logic [31:0] eInstr = '0;
    logic [31:0] ePc = '0;
    logic [31:0] eResult = '0;
    logic [4:0]  eWriteReg = '0;
    logic [31:0] eMemData = '0;
    logic        eRegWrite = 1'b0;
    logic [5:0]  eAluCtl = '0;
    logic        eMemRead = 1'b0;
    logic        eMemWrite = 1'b0;
    logic [5:0]  eMap = '0;
    logic        eBcast = 1'b0;

    // Redirect queue, two cycles deep
    logic        pendReq = 1'b0;
    logic [31:0] pendAddr = '0;
    logic        eReq = 1'b0;
    logic [31:0] eAddr = '0;

    // Reference ALU, reads HI/LO before the edge
    function automatic logic [31:0] aluRef(input logic [5:0] op, input logic [31:0] a,
                                           input logic [31:0] b, input logic [4:0] sh);
        logic [63:0] prod;
        prod = longint'($signed(a)) * longint'($signed(b));
        case (op)
            ALU_ADD:   return a + b;
            ALU_SUB:   return a - b;
            ALU_AND:   return a & b;
            ALU_OR:    return a | b;
            ALU_XOR:   return a ^ b;
            ALU_NOR:   return ~(a | b);
            ALU_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU:  return (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:   return b << sh;
            ALU_SRL:   return b >> sh;
            ALU_SRA:   return 32'($signed(b) >>> sh);
            ALU_LUI:   return {b[15:0], 16'h0};
            ALU_MULT:  return prod[31:0];
            ALU_MULTU: return a * b;
            ALU_MFHI:  return hiM;
            ALU_MFLO:  return loM;
            ALU_MTHI, ALU_MTLO, ALU_PASSA: return a;
            ALU_PASSB: return b;
            default:   return 32'h0;
        endcase
    endfunction

    // Reference branch decision
    function automatic logic takenRef(input logic [31:0] iw, input logic [31:0] a,
                                      input logic [31:0] b, input logic jmp);
        logic [5:0] op;
        logic [4:0] rt;
        op = iw[31:26];
        rt = iw[20:16];
        if (jmp) return 1'b1;
        if (op == OP_BEQ) return a == b;
        if (op == OP_BNE) return a != b;
        if (op == OP_BLEZ) return $signed(a) <= 0;
        if (op == OP_BGTZ) return $signed(a) > 0;
        if (op == OP_REGIMM && rt == RT_BLTZ) return $signed(a) < 0;
        if (op == OP_REGIMM && rt == RT_BGEZ) return $signed(a) >= 0;
        return 1'b0;
    endfunction

    // ************************************************************************
    // Model advance on each edge, inputs are stable here
    // ************************************************************************
    always @(posedge CLK or negedge RESET) begin
        logic        valid;
        logic        tk;
        logic        bc;
        logic [63:0] wide;
        if (!RESET) begin
            hiM = '0;
            loM = '0;
            {eInstr, ePc, eResult, eWriteReg, eMemData, eRegWrite} = '0;
            {eAluCtl, eMemRead, eMemWrite, eMap, eBcast} = '0;
            {pendReq, pendAddr, eReq, eAddr} = '0;
        end else begin
            valid = (InstrPc != 0);
            tk = takenRef(Instr, OperandA, OperandB, Jump);
            bc = valid && ((tk && Link) || (IssueRegWr && !MemRead));
            eInstr = Instr;
            ePc = InstrPc;
            eResult = aluRef(AluControl, OperandA, OperandB, ShiftAmount);
            eWriteReg = WriteReg;
            eMemData = MemWriteData;
            eRegWrite = bc ? 1'b0 : RegWrite;
            eAluCtl = AluControl;
            eMemRead = MemRead;
            eMemWrite = MemWrite;
            eMap = IssueRegWrMap;
            eBcast = bc;
            // Second redirect stage takes over the first
            eReq = pendReq;
            eAddr = pendAddr;
            pendReq = valid && tk;
            pendAddr = !pendReq ? 32'h0 : (JumpReg ? OperandA : BranchTarget);
            // HI/LO writes, bubbles skipped
            if (valid) begin
                if (AluControl == ALU_MULT) begin
                    wide = longint'($signed(OperandA)) * longint'($signed(OperandB));
                    {hiM, loM} = wide;
                end else if (AluControl == ALU_MULTU) begin
                    wide = {32'h0, OperandA} * {32'h0, OperandB};
                    {hiM, loM} = wide;
                end else if (AluControl == ALU_MTHI) begin
                    hiM = OperandA;
                end else if (AluControl == ALU_MTLO) begin
                    loM = OperandA;
                end
            end
        end
    end

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // ************************************************************************
    // Comparison in mid cycle, outputs settled
    // ************************************************************************
    always @(negedge CLK) begin
        // Only once reset is released
        if (RESET === 1'b1) begin
            compareField("InstrOut", InstrOut, eInstr);
            compareField("InstrPcOut", InstrPcOut, ePc);
            compareField("AluResultOut", AluResultOut, eResult);
            compareField("WriteRegOut", 32'(WriteRegOut), 32'(eWriteReg));
            compareField("MemWriteDataOut", MemWriteDataOut, eMemData);
            compareField("RegWriteOut", 32'(RegWriteOut), 32'(eRegWrite));
            compareField("AluControlOut", 32'(AluControlOut), 32'(eAluCtl));
            compareField("MemReadOut", 32'(MemReadOut), 32'(eMemRead));
            compareField("MemWriteOut", 32'(MemWriteOut), 32'(eMemWrite));
            compareField("RegWrMapOut", 32'(RegWrMapOut), 32'(eMap));
            compareField("BroadcastValid", 32'(BroadcastValid), 32'(eBcast));
            compareField("BroadcastMap", 32'(BroadcastMap), 32'(eMap));
            compareField("BroadcastReg", 32'(BroadcastReg), 32'(eWriteReg));
            compareField("BroadcastValue", BroadcastValue, eResult);
            compareField("RequestAltPc", 32'(RequestAltPc), 32'(eReq));
            compareField("AltAddr", AltAddr, eAddr);
            if (RequestAltPc && eReq) redirectCount++;
            if (BroadcastValid && eBcast) broadcastCount++;
        end
    end

endmodule

`default_nettype wire

// ==== bench/executeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module executeTb;
    import isaPkg::*;
    import exePkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int IDLE_CYCLES = 3;
    localparam int ALU_ITEMS = 2000;
    localparam int HILO_ITEMS = 600;
    localparam int BRANCH_ITEMS = 1000;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 2 * IDLE_CYCLES + ALU_ITEMS
                                + HILO_ITEMS + BRANCH_ITEMS;

    logic CLK;
    logic RESET;
    instrWord_t Instr;
    logic [`EXE_DATA_W-1:0] InstrPc;
    logic [`EXE_DATA_W-1:0] OperandA;
    logic [`EXE_DATA_W-1:0] OperandB;
    archReg_t WriteReg;
    logic [`EXE_DATA_W-1:0] MemWriteData;
    logic RegWrite;
    aluOp_t AluControl;
    logic MemRead;
    logic MemWrite;
    logic [4:0] ShiftAmount;
    logic [`EXE_DATA_W-1:0] BranchTarget;
    logic JumpReg;
    logic Jump;
    logic Link;
    physTag_t IssueRegWrMap;
    logic IssueRegWr;

    // DUT outputs
    instrWord_t InstrOut;
    logic [`EXE_DATA_W-1:0] InstrPcOut;
    logic [`EXE_DATA_W-1:0] AluResultOut;
    archReg_t WriteRegOut;
    logic [`EXE_DATA_W-1:0] MemWriteDataOut;
    logic RegWriteOut;
    aluOp_t AluControlOut;
    logic MemReadOut;
    logic MemWriteOut;
    physTag_t RegWrMapOut;
    logic BroadcastValid;
    physTag_t BroadcastMap;
    archReg_t BroadcastReg;
    logic [`EXE_DATA_W-1:0] BroadcastValue;
    logic RequestAltPc;
    logic [`EXE_DATA_W-1:0] AltAddr;

    logic [31:0] lfsr = 32'hf66a_07dd;

    executeTop dut (.*);

    // Checker sees the DUT ports through hierarchical names
    executeCheck chk (
        .CLK(CLK), .RESET(RESET), .Instr(dut.Instr), .InstrPc(dut.InstrPc),
        .OperandA(dut.OperandA), .OperandB(dut.OperandB), .WriteReg(dut.WriteReg),
        .MemWriteData(dut.MemWriteData), .RegWrite(dut.RegWrite),
        .AluControl(dut.AluControl), .MemRead(dut.MemRead), .MemWrite(dut.MemWrite),
        .ShiftAmount(dut.ShiftAmount), .BranchTarget(dut.BranchTarget),
        .JumpReg(dut.JumpReg), .Jump(dut.Jump), .Link(dut.Link),
        .IssueRegWrMap(dut.IssueRegWrMap), .IssueRegWr(dut.IssueRegWr),
        .InstrOut(dut.InstrOut), .InstrPcOut(dut.InstrPcOut),
        .AluResultOut(dut.AluResultOut), .WriteRegOut(dut.WriteRegOut),
        .MemWriteDataOut(dut.MemWriteDataOut), .RegWriteOut(dut.RegWriteOut),
        .AluControlOut(dut.AluControlOut), .MemReadOut(dut.MemReadOut),
        .MemWriteOut(dut.MemWriteOut), .RegWrMapOut(dut.RegWrMapOut),
        .BroadcastValid(dut.BroadcastValid), .BroadcastMap(dut.BroadcastMap),
        .BroadcastReg(dut.BroadcastReg), .BroadcastValue(dut.BroadcastValue),
        .RequestAltPc(dut.RequestAltPc), .AltAddr(dut.AltAddr)
    );

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // Idle inputs, a bubble with everything zero
    task automatic idleInputs();
        Instr = '0;
        {InstrPc, OperandA, OperandB, WriteReg, MemWriteData, RegWrite} = '0;
        AluControl = ALU_ADD;
        {MemRead, MemWrite, ShiftAmount, BranchTarget, JumpReg, Jump, Link} = '0;
        {IssueRegWrMap, IssueRegWr} = '0;
    endtask

    // Kind 0 plain ALU, 1 HI/LO traffic, 2 branches and jumps
    task automatic driveItem(input int kind);
        logic [31:0] code;
        logic [31:0] pick;
        Instr = randBits(32);
        InstrPc = (randBits(3) == 0) ? 32'h0 : (randBits(32) | 32'h400);
        OperandA = randBits(32);
        OperandB = (randBits(3) == 0) ? OperandA : randBits(32);
        WriteReg = archReg_t'(randBits(5));
        MemWriteData = randBits(32);
        RegWrite = 1'(randBits(1));
        MemRead = (randBits(2) == 0);
        MemWrite = 1'(randBits(1));
        ShiftAmount = 5'(randBits(5));
        BranchTarget = randBits(32);
        JumpReg = 1'(randBits(1));
        Jump = 1'b0;
        Link = 1'(randBits(1));
        IssueRegWrMap = physTag_t'(randBits(6));
        IssueRegWr = 1'(randBits(1));
        if (kind == 0) begin
            code = randBits(4) % 14;
            AluControl = aluOp_t'(6'((code < 12) ? code : code + 6));
        end else if (kind == 1) begin
            AluControl = aluOp_t'(6'(randBits(3) % 6 + 12));
        end else begin
            AluControl = aluOp_t'(6'(randBits(5) % 20));
            // Weighted toward the five branch opcodes
            pick = randBits(3);
            case (pick)
                0: Instr.i.opcode = OP_BEQ;
                1: Instr.i.opcode = OP_BNE;
                2: Instr.i.opcode = OP_BLEZ;
                3: Instr.i.opcode = OP_BGTZ;
                4, 5: Instr.i.opcode = OP_REGIMM;
                default: ;
            endcase
            if (randBits(1)) Instr.i.rt = 5'(randBits(1));
            if (randBits(2) == 0) OperandA = 32'h0;
            Jump = (randBits(2) == 0);
        end
    endtask

    task automatic runItems(input int kind, input int count);
        repeat (count) begin
            @(posedge CLK);
            #1;
            driveItem(kind);
        end
    endtask

    task automatic runIdle(input int count);
        repeat (count) begin
            @(posedge CLK);
            #1;
            idleInputs();
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        $display("%s finished with %0d errors", name, chk.errorCount - errorsBefore);
    endtask

    // ************************************************************************
    // Test sequence
    // ************************************************************************
    initial begin
        int base;
        idleInputs();
        RESET = 1'b0;
        base = 0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        RESET = 1'b1;
        runIdle(IDLE_CYCLES);
        reportTest("Reset state test", base);
        base = chk.errorCount;
        runItems(0, ALU_ITEMS);
        reportTest("ALU and pass-through test", base);
        base = chk.errorCount;
        runItems(1, HILO_ITEMS);
        reportTest("HI/LO test", base);
        base = chk.errorCount;
        // Consecutive branch items, so redirects run back to back
        runItems(2, BRANCH_ITEMS);
        runIdle(IDLE_CYCLES);
        reportTest("Branch, redirect and broadcast test", base);
        $display("Checks %0d, errors %0d, redirects %0d, broadcasts %0d",
                 chk.checkCount, chk.errorCount, chk.redirectCount, chk.broadcastCount);
        if (chk.errorCount == 0 && chk.redirectCount > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog over the whole test length plus margin
    initial begin
        #((TOTAL_CYCLES + 10) * 8);
        $display("Timeout, the tests did not finish in the expected time");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+design
design/isaPkg.sv
design/exePkg.sv
design/branchCompare.sv
design/aluUnit.sv
design/redirectUnit.sv
design/exeStageReg.sv
design/executeTop.sv
bench/executeChecker.sv
bench/executeTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module executeTb \
    -o simExecute > build.log 2>&1 &&
./obj_dir/simExecute > sim.log 2>&1 ||
{ echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "^TEST PASS$" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed, see sim.log"; exit 1; }
